// ==== src.f ====
logic/decode_pkg.sv
logic/insn_capture.sv
logic/op_classify.sv
logic/operand_select.sv
logic/decode_pipe.sv
tests/decode_pipe_props.sv
tests/decode_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build with Verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f src.f --top-module decode_pipe_tb \
	-o decode_pipe_sim || exit 1
./obj_dir/decode_pipe_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log
grep -q '^>>> PASS$' sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== tests/decode_pipe_tb.sv ====
`timescale 1ns/10ps

module decode_pipe_tb;
	import decode_pkg::*;

	localparam int PC_W      = 32;
	localparam int PRF_IDX_W = 6;
	localparam int SLOTS     = 200;
	localparam int NUM_TESTS = 6;
	localparam int LIMIT     = NUM_TESTS * SLOTS + 100;

	logic                 clk;
	logic                 rst_n;
	logic                 insn_valid;
	logic [31:0]          insn;
	logic [PC_W-1:0]      pc;
	logic                 insn_pred;
	logic [7:0]           pht_idx;
	logic [PC_W-1:0]      insn_pred_target;
	logic                 uop_valid;
	uop_op_t              uop_op;
	logic [PRF_IDX_W-1:0] src_a, src_b, dst;
	logic                 src_a_valid, src_b_valid, dst_valid;
	logic [15:0]          imm;
	logic [PC_W-17:0]     jmp_imm;
	logic [PC_W-1:0]      uop_pc;
	logic                 br_pred;
	logic [7:0]           uop_pht_idx;
	logic                 is_br, is_mem, is_store;
	logic                 has_delay_slot, has_nullifying_delay_slot;

	logic [31:0] rng_state = 32'd51133;
	int          cycles = 0;
	int          errors_before;

	// opcode and funct pools
	logic [5:0] r_fns[14] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV, FN_ADDU,
		FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
	logic [5:0] i_ops[7]  = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI};
	logic [5:0] ld_ops[5] = '{OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU};
	logic [5:0] st_ops[3] = '{OP_SB, OP_SH, OP_SW};
	logic [5:0] br_ops[8] = '{OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ, OP_BEQL, OP_BNEL,
		OP_BLEZL, OP_BGTZL};
	logic [4:0] ri_rts[5] = '{RT_BLTZ, RT_BGEZ, RT_BLTZL, RT_BGEZL, RT_BGEZAL};
	logic [5:0] bad_ops[10] = '{6'd8, 6'd16, 6'd17, 6'd28, 6'd31, 6'd34, 6'd38, 6'd46,
		6'd48, 6'd51};
	logic [5:0] bad_fns[8]  = '{6'd1, 6'd5, 6'd12, 6'd13, 6'd16, 6'd24, 6'd32, 6'd34};
	logic [4:0] bad_rts[4]  = '{5'd4, 5'd8, 5'd16, 5'd18};

	decode_pipe #(.PC_W(PC_W), .PRF_IDX_W(PRF_IDX_W)) decode_pipe_inst (.*);

	bind decode_pipe decode_pipe_props #(.PC_W(PC_W), .PRF_IDX_W(PRF_IDX_W)) props_inst (.*);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	// register field, zero about one time in four
	function automatic logic [4:0] reg_field();
		logic [31:0] r;
		r = next_rand();
		return (r[1:0] == 2'd0) ? 5'd0 : r[8:4];
	endfunction

	function automatic logic [31:0] r_alu_word();
		logic [31:0] r;
		r = next_rand();
		return {OP_SPECIAL, reg_field(), reg_field(), reg_field(), r[4:0], r_fns[r[31:8] % 14]};
	endfunction

	function automatic logic [31:0] i_alu_word();
		logic [31:0] r;
		r = next_rand();
		return {i_ops[r[31:8] % 7], reg_field(), reg_field(), r[15:0]};
	endfunction

	function automatic logic [31:0] mem_word();
		logic [31:0] r;
		r = next_rand();
		if (r[0])
			return {st_ops[r[31:8] % 3], reg_field(), reg_field(), r[23:8]};
		return {ld_ops[r[31:8] % 5], reg_field(), reg_field(), r[23:8]};
	endfunction

	function automatic logic [31:0] branch_word();
		logic [31:0] r;
		r = next_rand();
		case (r[2:0])
			3'd0:    return {OP_J, r[31:6]};
			3'd1:    return {OP_JAL, r[31:6]};
			3'd2:    return {OP_SPECIAL, reg_field(), 15'd0, FN_JR};
			3'd3:    return {OP_SPECIAL, reg_field(), 5'd0, reg_field(), 5'd0, FN_JALR};
			3'd4:    return {OP_REGIMM, reg_field(), ri_rts[r[31:8] % 5], r[23:8]};
			default: return {br_ops[r[31:8] % 8], reg_field(), reg_field(), r[23:8]};
		endcase
	endfunction

	// writes aimed at r0 plus the link forms
	function automatic logic [31:0] fold_word();
		logic [31:0] r;
		logic [31:0] x;
		r = next_rand();
		x = next_rand();
		case (r[1:0])
			2'd0:    return {x[31:16], 5'd0, x[10:0]} & 32'h03ff_ffc0
				| {OP_SPECIAL, 20'd0, r_fns[r[31:8] % 14]};
			2'd1:    return {i_ops[r[31:8] % 7], x[4:0], 5'd0, x[31:16]};
			2'd2:    return {ld_ops[r[31:8] % 5], x[4:0], 5'd0, x[31:16]};
			default: return r[2] ? {OP_JAL, x[25:0]} : {OP_REGIMM, reg_field(), RT_BGEZAL, x[15:0]};
		endcase
	endfunction

	function automatic logic [31:0] illegal_word();
		logic [31:0] r;
		logic [31:0] x;
		r = next_rand();
		x = next_rand();
		case (r[1:0])
			2'd0:    return {OP_SPECIAL, x[25:6], bad_fns[r[31:8] % 8]};
			2'd1:    return {OP_REGIMM, x[4:0], bad_rts[r[31:8] % 4], x[31:16]};
			default: return {bad_ops[r[31:8] % 10], x[25:0]};
		endcase
	endfunction

	function automatic logic [31:0] make_word(input int test);
		logic [31:0] r;
		case (test)
			2: return r_alu_word();
			3: return fold_word();
			4: return mem_word();
			5: return branch_word();
			6: return illegal_word();
			default:
			begin
				r = next_rand();
				case (r[2:0])
					3'd0, 3'd1: return r_alu_word();
					3'd2, 3'd3: return i_alu_word();
					3'd4:       return mem_word();
					3'd5:       return illegal_word();
					default:    return branch_word();
				endcase
			end
		endcase
	endfunction

	task automatic run_test(input int num, input string name);
		logic [31:0] r;
		errors_before = decode_pipe_inst.props_inst.fail_count;
		for (int i = 0; i < SLOTS; i++)
		begin
			@(posedge clk);
			#2;
			r = next_rand();
			insn_valid = (r[2:0] != 3'd0) && !(r[9:8] == 2'd0 && r[3]); // runs with gaps
			insn = make_word(num);
			pc = next_rand() & ~32'd3;
			insn_pred = r[12];
			pht_idx = r[23:16];
			insn_pred_target = next_rand();
		end
		@(posedge clk);
		#2;
		insn_valid = 1'b0;
		repeat (4) @(posedge clk); // drain the pipe
		$display("test %0d %s: %0d errors", num, name,
			decode_pipe_inst.props_inst.fail_count - errors_before);
	endtask

	always @(posedge clk)
	begin
		cycles++;
		if (cycles >= LIMIT)
		begin
			$display("timeout: the run did not finish within %0d cycles", LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial
	begin
		rst_n = 1'b0;
		insn_valid = 1'b0;
		insn = '0;
		pc = '0;
		insn_pred = 1'b0;
		pht_idx = '0;
		insn_pred_target = '0;
		repeat (4) @(posedge clk);
		#2;
		rst_n = 1'b1;
		run_test(1, "pipeline timing and order");
		run_test(2, "r-type alu operands");
		run_test(3, "zero destination folding");
		run_test(4, "loads and stores");
		run_test(5, "branches and jumps");
		run_test(6, "illegal words");
		$display("tests run %0d, assertion failures %0d", NUM_TESTS,
			decode_pipe_inst.props_inst.fail_count);
		if (decode_pipe_inst.props_inst.fail_count == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== tests/decode_pipe_props.sv ====
`timescale 1ns/10ps

module decode_pipe_props #(
	parameter int PC_W      = 32,
	parameter int PRF_IDX_W = 6
) (
	input logic                 clk,
	input logic                 rst_n,
	input logic                 insn_valid,
	input logic [31:0]          insn,
	input logic [PC_W-1:0]      pc,
	input logic                 insn_pred,
	input logic [7:0]           pht_idx,
	input logic [PC_W-1:0]      insn_pred_target,
	input logic                 uop_valid,
	input decode_pkg::uop_op_t  uop_op,
	input logic [PRF_IDX_W-1:0] src_a,
	input logic                 src_a_valid,
	input logic [PRF_IDX_W-1:0] src_b,
	input logic                 src_b_valid,
	input logic [PRF_IDX_W-1:0] dst,
	input logic                 dst_valid,
	input logic [15:0]          imm,
	input logic [PC_W-17:0]     jmp_imm,
	input logic [PC_W-1:0]      uop_pc,
	input logic                 br_pred,
	input logic [7:0]           uop_pht_idx,
	input logic                 is_br,
	input logic                 is_mem,
	input logic                 is_store,
	input logic                 has_delay_slot,
	input logic                 has_nullifying_delay_slot
);
	import decode_pkg::*;

	int fail_count = 0;

	// inputs as seen three edges back
	logic [2:0]            v_q;
	logic [2:0][31:0]      w_q;
	logic [2:0][PC_W-1:0]  pc_q;
	logic [2:0][PC_W-1:0]  tgt_q;
	logic [2:0][7:0]       pht_q;
	logic [2:0]            pred_q;

	logic [31:0]      w;
	uop_op_t          e_op;
	logic             a_ok, b_ok, d_ok, fold, r_alu, shift;
	logic [4:0]       a, b, d;
	logic             src_chk, b_val_chk, imm_chk, jmp_chk, brp_chk;
	logic [15:0]      e_imm;
	logic [PC_W-17:0] e_jmp;
	logic             e_br, e_mem, e_st, e_ds, e_nds, e_brp;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			v_q <= '0;
		else
			v_q <= {v_q[1:0], insn_valid};
	end

	always_ff @(posedge clk)
	begin
		w_q    <= {w_q[1:0], insn};
		pc_q   <= {pc_q[1:0], pc};
		tgt_q  <= {tgt_q[1:0], insn_pred_target};
		pht_q  <= {pht_q[1:0], pht_idx};
		pred_q <= {pred_q[1:0], insn_pred};
	end

	// reference decode straight from the MIPS32 field rules
	always_comb
	begin
		w = w_q[2];
		e_op = II;
		{a_ok, b_ok, d_ok, fold, r_alu, shift} = '0;
		{a, b, d} = '0;
		{src_chk, b_val_chk, imm_chk, jmp_chk, brp_chk} = '0;
		e_imm = '0;
		e_jmp = '0;
		{e_br, e_mem, e_st, e_ds, e_nds, e_brp} = '0;
		case (w[31:26])
			OP_SPECIAL:
			begin
				case (w[5:0])
					FN_SLL:  e_op = SLL;
					FN_SRL:  e_op = SRL;
					FN_SRA:  e_op = SRA;
					FN_SLLV: e_op = SLLV;
					FN_SRLV: e_op = SRLV;
					FN_SRAV: e_op = SRAV;
					FN_ADDU: e_op = ADDU;
					FN_SUBU: e_op = SUBU;
					FN_AND:  e_op = AND;
					FN_OR:   e_op = (w[25:21] == 5'd0) ? MOV : OR;
					FN_XOR:  e_op = XOR;
					FN_NOR:  e_op = NOR;
					FN_SLT:  e_op = SLT;
					FN_SLTU: e_op = SLTU;
					FN_JR:   e_op = JR;
					FN_JALR: e_op = JALR;
					default: e_op = II;
				endcase
				r_alu = !(e_op inside {II, JR, JALR});
			end
			OP_REGIMM:
			begin
				case (w[20:16])
					RT_BLTZ:   e_op = BLTZ;
					RT_BGEZ:   e_op = BGEZ;
					RT_BLTZL:  e_op = BLTZL;
					RT_BGEZL:  e_op = BGEZL;
					RT_BGEZAL: e_op = (w[25:21] == 5'd0) ? BAL : BGEZAL;
					default:   e_op = II;
				endcase
			end
			OP_J:     e_op = J;
			OP_JAL:   e_op = JAL;
			OP_BEQ:   e_op = BEQ;
			OP_BNE:   e_op = BNE;
			OP_BLEZ:  e_op = BLEZ;
			OP_BGTZ:  e_op = BGTZ;
			OP_BEQL:  e_op = BEQL;
			OP_BNEL:  e_op = BNEL;
			OP_BLEZL: e_op = BLEZL;
			OP_BGTZL: e_op = BGTZL;
			OP_ADDIU: e_op = (w[25:21] == 5'd0) ? MOVI : ADDIU;
			OP_SLTI:  e_op = SLTI;
			OP_SLTIU: e_op = SLTIU;
			OP_ANDI:  e_op = ANDI;
			OP_ORI:   e_op = ORI;
			OP_XORI:  e_op = XORI;
			OP_LUI:   e_op = LUI;
			OP_LB:    e_op = LB;
			OP_LH:    e_op = LH;
			OP_LW:    e_op = LW;
			OP_LBU:   e_op = LBU;
			OP_LHU:   e_op = LHU;
			OP_SB:    e_op = SB;
			OP_SH:    e_op = SH;
			OP_SW:    e_op = SW;
			default:  e_op = II;
		endcase

		if (r_alu)
		begin
			src_chk = 1'b1;
			d = w[15:11];
			fold = 1'b1;
			shift = (e_op inside {SLL, SRL, SRA});
			a_ok = 1'b1;
			a = (e_op == SUBU) ? w[25:21] : w[20:16];
			b_ok = !shift && e_op != MOV;
			b = shift ? w[10:6] : (e_op == SUBU) ? w[20:16] : w[25:21];
			b_val_chk = b_ok || shift; // shamt is carried but not a read
		end
		if (e_op inside {ADDIU, MOVI, SLTI, SLTIU, ANDI, ORI, XORI, LUI})
		begin
			src_chk = 1'b1;
			a_ok = !(e_op inside {MOVI, LUI});
			a = w[25:21];
			d = w[20:16];
			fold = 1'b1;
			imm_chk = 1'b1;
			e_imm = w[15:0];
		end
		if (e_op inside {LB, LH, LW, LBU, LHU, SB, SH, SW})
		begin
			src_chk = 1'b1;
			e_mem = 1'b1;
			e_st = (e_op inside {SB, SH, SW});
			a_ok = 1'b1;
			a = w[25:21];
			b_ok = e_st;
			b = w[20:16];
			b_val_chk = e_st;
			d = w[20:16];
			fold = !e_st;
			imm_chk = 1'b1;
			e_imm = w[15:0];
		end
		if (e_op inside {BEQ, BNE, BLEZ, BGTZ, BEQL, BNEL, BLEZL, BGTZL,
			BLTZ, BGEZ, BLTZL, BGEZL, BGEZAL, BAL})
		begin
			e_br = 1'b1;
			e_ds = 1'b1;
			e_brp = pred_q[2];
			brp_chk = 1'b1;
		end
		e_nds = (e_op inside {BEQL, BNEL, BLEZL, BGTZL, BLTZL, BGEZL});
		if (e_op inside {J, JAL, JR, JALR})
		begin
			e_br = 1'b1;
			e_ds = 1'b1;
		end
		if (e_op inside {BGEZAL, BAL, JAL})
		begin
			d = REG_LINK;
			d_ok = 1'b1; // link writes are never folded
		end
		if (e_op == JAL)
		begin
			e_brp = 1'b1;
			brp_chk = 1'b1;
			imm_chk = 1'b1;
			jmp_chk = 1'b1;
			e_imm = w[15:0];
			e_jmp = (PC_W-16)'(w[25:16]);
		end
		if (e_op inside {JR, JALR})
		begin
			imm_chk = 1'b1;
			jmp_chk = 1'b1;
			e_imm = tgt_q[2][15:0];
			e_jmp = tgt_q[2][PC_W-1:16];
			d = (e_op == JALR) ? w[15:11] : 5'd0;
			d_ok = (d != 5'd0);
		end
		if (e_op == II)
			src_chk = 1'b1; // all valid bits low
		if (fold)
		begin
			d_ok = (d != 5'd0);
			if (!d_ok)
				e_op = NOP;
		end
	end

	a_valid: assert property (@(posedge clk) disable iff (!rst_n) uop_valid == v_q[2])
		else begin
			fail_count++;
			$error("Mismatch at %0t: uop_valid got %0b expected %0b",
				$time, $sampled(uop_valid), $sampled(v_q[2]));
		end

	a_pc: assert property (@(posedge clk) disable iff (!rst_n)
		uop_valid |-> uop_pc == pc_q[2] && uop_pht_idx == pht_q[2])
		else begin
			fail_count++;
			$error("Mismatch at %0t: uop_pc/uop_pht_idx got %0h/%0h expected %0h/%0h",
				$time, $sampled(uop_pc), $sampled(uop_pht_idx),
				$sampled(pc_q[2]), $sampled(pht_q[2]));
		end

	a_op: assert property (@(posedge clk) disable iff (!rst_n) uop_valid |-> uop_op == e_op)
		else begin
			fail_count++;
			$error("Mismatch at %0t: uop_op got %0d expected %0d",
				$time, $sampled(uop_op), $sampled(e_op));
		end

	a_dst: assert property (@(posedge clk) disable iff (!rst_n)
		uop_valid |-> dst_valid == d_ok && (!d_ok || dst == PRF_IDX_W'(d)))
		else begin
			fail_count++;
			$error("Mismatch at %0t: dst got %0b/%0d expected %0b/%0d", $time,
				$sampled(dst_valid), $sampled(dst), $sampled(d_ok), $sampled(d));
		end

	a_src: assert property (@(posedge clk) disable iff (!rst_n)
		uop_valid && src_chk |-> src_a_valid == a_ok && src_b_valid == b_ok
		&& (!a_ok || src_a == PRF_IDX_W'(a)) && (!b_val_chk || src_b == PRF_IDX_W'(b)))
		else begin
			fail_count++;
			$error("Mismatch at %0t: src_a/src_b got %0b:%0d %0b:%0d expected %0b:%0d %0b:%0d",
				$time, $sampled(src_a_valid), $sampled(src_a), $sampled(src_b_valid),
				$sampled(src_b), $sampled(a_ok), $sampled(a), $sampled(b_ok), $sampled(b));
		end

	a_imm: assert property (@(posedge clk) disable iff (!rst_n)
		uop_valid && imm_chk |-> imm == e_imm && (!jmp_chk || jmp_imm == e_jmp))
		else begin
			fail_count++;
			$error("Mismatch at %0t: imm/jmp_imm got %0h/%0h expected %0h/%0h", $time,
				$sampled(imm), $sampled(jmp_imm), $sampled(e_imm), $sampled(e_jmp));
		end

	a_flags: assert property (@(posedge clk) disable iff (!rst_n)
		uop_valid |-> {is_br, is_mem, is_store, has_delay_slot, has_nullifying_delay_slot}
		== {e_br, e_mem, e_st, e_ds, e_nds})
		else begin
			fail_count++;
			$error("Mismatch at %0t: class flags got %05b expected %05b", $time,
				$sampled({is_br, is_mem, is_store, has_delay_slot, has_nullifying_delay_slot}),
				$sampled({e_br, e_mem, e_st, e_ds, e_nds}));
		end

	a_pred: assert property (@(posedge clk) disable iff (!rst_n)
		uop_valid && brp_chk |-> br_pred == e_brp)
		else begin
			fail_count++;
			$error("Mismatch at %0t: br_pred got %0b expected %0b",
				$time, $sampled(br_pred), $sampled(e_brp));
		end

endmodule

// ==== logic/decode_pipe.sv ====
`timescale 1ns/10ps

module decode_pipe #(
	parameter int PC_W      = 32,
	parameter int PRF_IDX_W = 6
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 insn_valid,
	input  logic [31:0]          insn,
	input  logic [PC_W-1:0]      pc,
	input  logic                 insn_pred,
	input  logic [7:0]           pht_idx,
	input  logic [PC_W-1:0]      insn_pred_target,
	output logic                 uop_valid,
	output decode_pkg::uop_op_t  uop_op,
	output logic [PRF_IDX_W-1:0] src_a,
	output logic                 src_a_valid,
	output logic [PRF_IDX_W-1:0] src_b,
	output logic                 src_b_valid,
	output logic [PRF_IDX_W-1:0] dst,
	output logic                 dst_valid,
	output logic [15:0]          imm,
	output logic [PC_W-17:0]     jmp_imm,
	output logic [PC_W-1:0]      uop_pc,
	output logic                 br_pred,
	output logic [7:0]           uop_pht_idx,
	output logic                 is_br,
	output logic                 is_mem,
	output logic                 is_store,
	output logic                 has_delay_slot,
	output logic                 has_nullifying_delay_slot
);
	import decode_pkg::*;

	// stage 1 to 2
	logic             s1_valid;
	insn_word_t       s1_insn;
	logic [PC_W-1:0]  s1_pc;
	logic             s1_pred;
	logic [7:0]       s1_pht_idx;
	logic [PC_W-1:0]  s1_pred_target;

	// stage 2 to 3
	logic             s2_valid;
	insn_word_t       s2_insn;
	logic [PC_W-1:0]  s2_pc;
	logic [7:0]       s2_pht_idx;
	logic [PC_W-1:0]  s2_pred_target;
	uop_op_t          s2_op;
	src_sel_t         src_a_sel;
	src_sel_t         src_b_sel;
	dst_sel_t         dst_sel;
	imm_sel_t         imm_sel;
	logic             s2_br_pred;
	logic             s2_is_br;
	logic             s2_is_mem;
	logic             s2_is_store;
	logic             s2_has_delay_slot;
	logic             s2_has_nullifying_delay_slot;
	logic             may_fold;

	insn_capture #(.PC_W(PC_W)) insn_capture_inst (
		.clk(clk),
		.rst_n(rst_n),
		.insn_valid(insn_valid),
		.insn(insn),
		.pc(pc),
		.insn_pred(insn_pred),
		.pht_idx(pht_idx),
		.insn_pred_target(insn_pred_target),
		.s1_valid(s1_valid),
		.s1_insn(s1_insn),
		.s1_pc(s1_pc),
		.s1_pred(s1_pred),
		.s1_pht_idx(s1_pht_idx),
		.s1_pred_target(s1_pred_target)
	);

	op_classify #(.PC_W(PC_W)) op_classify_inst (
		.clk(clk),
		.rst_n(rst_n),
		.s1_valid(s1_valid),
		.s1_insn(s1_insn),
		.s1_pc(s1_pc),
		.s1_pred(s1_pred),
		.s1_pht_idx(s1_pht_idx),
		.s1_pred_target(s1_pred_target),
		.s2_valid(s2_valid),
		.s2_insn(s2_insn),
		.s2_pc(s2_pc),
		.s2_pht_idx(s2_pht_idx),
		.s2_pred_target(s2_pred_target),
		.s2_op(s2_op),
		.src_a_sel(src_a_sel),
		.src_b_sel(src_b_sel),
		.dst_sel(dst_sel),
		.imm_sel(imm_sel),
		.s2_br_pred(s2_br_pred),
		.s2_is_br(s2_is_br),
		.s2_is_mem(s2_is_mem),
		.s2_is_store(s2_is_store),
		.s2_has_delay_slot(s2_has_delay_slot),
		.s2_has_nullifying_delay_slot(s2_has_nullifying_delay_slot),
		.may_fold(may_fold)
	);

	operand_select #(.PC_W(PC_W), .PRF_IDX_W(PRF_IDX_W)) operand_select_inst (
		.clk(clk),
		.rst_n(rst_n),
		.s2_valid(s2_valid),
		.s2_insn(s2_insn),
		.s2_pc(s2_pc),
		.s2_pht_idx(s2_pht_idx),
		.s2_pred_target(s2_pred_target),
		.s2_op(s2_op),
		.src_a_sel(src_a_sel),
		.src_b_sel(src_b_sel),
		.dst_sel(dst_sel),
		.imm_sel(imm_sel),
		.s2_br_pred(s2_br_pred),
		.s2_is_br(s2_is_br),
		.s2_is_mem(s2_is_mem),
		.s2_is_store(s2_is_store),
		.s2_has_delay_slot(s2_has_delay_slot),
		.s2_has_nullifying_delay_slot(s2_has_nullifying_delay_slot),
		.may_fold(may_fold),
		.uop_valid(uop_valid),
		.uop_op(uop_op),
		.src_a(src_a),
		.src_a_valid(src_a_valid),
		.src_b(src_b),
		.src_b_valid(src_b_valid),
		.dst(dst),
		.dst_valid(dst_valid),
		.imm(imm),
		.jmp_imm(jmp_imm),
		.uop_pc(uop_pc),
		.br_pred(br_pred),
		.uop_pht_idx(uop_pht_idx),
		.is_br(is_br),
		.is_mem(is_mem),
		.is_store(is_store),
		.has_delay_slot(has_delay_slot),
		.has_nullifying_delay_slot(has_nullifying_delay_slot)
	);

endmodule

// ==== logic/operand_select.sv ====
`timescale 1ns/10ps

module operand_select #(
	parameter int PC_W      = 32,
	parameter int PRF_IDX_W = 6
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   s2_valid,
	input  decode_pkg::insn_word_t s2_insn,
	input  logic [PC_W-1:0]        s2_pc,
	input  logic [7:0]             s2_pht_idx,
	input  logic [PC_W-1:0]        s2_pred_target,
	input  decode_pkg::uop_op_t    s2_op,
	input  decode_pkg::src_sel_t   src_a_sel,
	input  decode_pkg::src_sel_t   src_b_sel,
	input  decode_pkg::dst_sel_t   dst_sel,
	input  decode_pkg::imm_sel_t   imm_sel,
	input  logic                   s2_br_pred,
	input  logic                   s2_is_br,
	input  logic                   s2_is_mem,
	input  logic                   s2_is_store,
	input  logic                   s2_has_delay_slot,
	input  logic                   s2_has_nullifying_delay_slot,
	input  logic                   may_fold,
	output logic                   uop_valid,
	output decode_pkg::uop_op_t    uop_op,
	output logic [PRF_IDX_W-1:0]   src_a,
	output logic                   src_a_valid,
	output logic [PRF_IDX_W-1:0]   src_b,
	output logic                   src_b_valid,
	output logic [PRF_IDX_W-1:0]   dst,
	output logic                   dst_valid,
	output logic [15:0]            imm,
	output logic [PC_W-17:0]       jmp_imm,
	output logic [PC_W-1:0]        uop_pc,
	output logic                   br_pred,
	output logic [7:0]             uop_pht_idx,
	output logic                   is_br,
	output logic                   is_mem,
	output logic                   is_store,
	output logic                   has_delay_slot,
	output logic                   has_nullifying_delay_slot
);
	import decode_pkg::*;

	logic [PRF_IDX_W-1:0] dst_d;
	logic                 dst_ok;
	uop_op_t              op_d;
	logic [15:0]          imm_d;
	logic [PC_W-17:0]     jmp_imm_d;

	// zero padded register index for a source selector
	function automatic logic [PRF_IDX_W-1:0] src_index(input src_sel_t sel, input insn_word_t w);
		case (sel)
			SRC_RS:    return PRF_IDX_W'(w.r.rs);
			SRC_RT:    return PRF_IDX_W'(w.r.rt);
			SRC_SHAMT: return PRF_IDX_W'(w.r.shamt);
			SRC_LINK:  return PRF_IDX_W'(REG_LINK);
			default:   return '0;
		endcase
	endfunction

	always_comb
	begin
		case (dst_sel)
			DST_RD:   dst_d = PRF_IDX_W'(s2_insn.r.rd);
			DST_RT:   dst_d = PRF_IDX_W'(s2_insn.r.rt);
			DST_LINK: dst_d = PRF_IDX_W'(REG_LINK);
			default:  dst_d = '0;
		endcase
		// writes to r0 vanish, link writes always stand
		dst_ok = (dst_sel == DST_LINK) || (dst_sel != DST_NONE && dst_d != '0);
		op_d = (may_fold && !dst_ok) ? NOP : s2_op;
	end

	always_comb
	begin
		imm_d = '0;
		jmp_imm_d = '0;
		case (imm_sel)
			IMM_16:
				imm_d = s2_insn.i.imm16;
			IMM_JUMP:
			begin
				imm_d = s2_insn.i.imm16;
				jmp_imm_d = (PC_W-16)'({s2_insn.r.rs, s2_insn.r.rt}); // insn[25:16]
			end
			IMM_PRED:
			begin
				imm_d = s2_pred_target[15:0];
				jmp_imm_d = s2_pred_target[PC_W-1:16];
			end
			default:
				imm_d = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			uop_valid <= 1'b0;
		else
			uop_valid <= s2_valid;
	end

	always_ff @(posedge clk)
	begin
		if (s2_valid)
		begin
			uop_op <= op_d;
			src_a <= src_index(src_a_sel, s2_insn);
			src_a_valid <= (src_a_sel != SRC_NONE) && (src_a_sel != SRC_SHAMT);
			src_b <= src_index(src_b_sel, s2_insn);
			src_b_valid <= (src_b_sel != SRC_NONE) && (src_b_sel != SRC_SHAMT); // shamt is no read
			dst <= dst_d;
			dst_valid <= dst_ok;
			imm <= imm_d;
			jmp_imm <= jmp_imm_d;
			uop_pc <= s2_pc;
			br_pred <= s2_br_pred;
			uop_pht_idx <= s2_pht_idx;
			is_br <= s2_is_br;
			is_mem <= s2_is_mem;
			is_store <= s2_is_store;
			has_delay_slot <= s2_has_delay_slot;
			has_nullifying_delay_slot <= s2_has_nullifying_delay_slot;
		end
	end

endmodule

// ==== logic/op_classify.sv ====
`timescale 1ns/10ps

module op_classify #(
	parameter int PC_W = 32
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   s1_valid,
	input  decode_pkg::insn_word_t s1_insn,
	input  logic [PC_W-1:0]        s1_pc,
	input  logic                   s1_pred,
	input  logic [7:0]             s1_pht_idx,
	input  logic [PC_W-1:0]        s1_pred_target,
	output logic                   s2_valid,
	output decode_pkg::insn_word_t s2_insn,
	output logic [PC_W-1:0]        s2_pc,
	output logic [7:0]             s2_pht_idx,
	output logic [PC_W-1:0]        s2_pred_target,
	output decode_pkg::uop_op_t    s2_op,
	output decode_pkg::src_sel_t   src_a_sel,
	output decode_pkg::src_sel_t   src_b_sel,
	output decode_pkg::dst_sel_t   dst_sel,
	output decode_pkg::imm_sel_t   imm_sel,
	output logic                   s2_br_pred,
	output logic                   s2_is_br,
	output logic                   s2_is_mem,
	output logic                   s2_is_store,
	output logic                   s2_has_delay_slot,
	output logic                   s2_has_nullifying_delay_slot,
	output logic                   may_fold
);
	import decode_pkg::*;

	uop_op_t  op_d;
	src_sel_t a_sel_d;
	src_sel_t b_sel_d;
	dst_sel_t dst_sel_d;
	imm_sel_t imm_sel_d;
	logic     br_pred_d;
	logic     is_br_d;
	logic     is_mem_d;
	logic     is_store_d;
	logic     delay_d;
	logic     nullify_d;
	logic     fold_d;

	// opcode, funct or regimm rt down to one micro-op; II when not kept
	function automatic uop_op_t base_op(input insn_word_t w);
		logic rs_zero;
		rs_zero = (w.r.rs == 5'd0);
		case (w.r.opcode)
			OP_SPECIAL:
			begin
				case (w.r.funct)
					FN_SLL:  return SLL;
					FN_SRL:  return SRL;
					FN_SRA:  return SRA;
					FN_SLLV: return SLLV;
					FN_SRLV: return SRLV;
					FN_SRAV: return SRAV;
					FN_JR:   return JR;
					FN_JALR: return JALR;
					FN_ADDU: return ADDU;
					FN_SUBU: return SUBU;
					FN_AND:  return AND;
					FN_OR:   return rs_zero ? MOV : OR; // or rd, r0, rt is a plain move
					FN_XOR:  return XOR;
					FN_NOR:  return NOR;
					FN_SLT:  return SLT;
					FN_SLTU: return SLTU;
					default: return II;
				endcase
			end
			OP_REGIMM:
			begin
				case (w.r.rt)
					RT_BLTZ:   return BLTZ;
					RT_BGEZ:   return BGEZ;
					RT_BLTZL:  return BLTZL;
					RT_BGEZL:  return BGEZL;
					RT_BGEZAL: return rs_zero ? BAL : BGEZAL; // r0 >= 0 always holds
					default:   return II;
				endcase
			end
			OP_J:     return J;
			OP_JAL:   return JAL;
			OP_BEQ:   return BEQ;
			OP_BNE:   return BNE;
			OP_BLEZ:  return BLEZ;
			OP_BGTZ:  return BGTZ;
			OP_BEQL:  return BEQL;
			OP_BNEL:  return BNEL;
			OP_BLEZL: return BLEZL;
			OP_BGTZL: return BGTZL;
			OP_ADDIU: return rs_zero ? MOVI : ADDIU;
			OP_SLTI:  return SLTI;
			OP_SLTIU: return SLTIU;
			OP_ANDI:  return ANDI;
			OP_ORI:   return ORI;
			OP_XORI:  return XORI;
			OP_LUI:   return LUI;
			OP_LB:    return LB;
			OP_LH:    return LH;
			OP_LW:    return LW;
			OP_LBU:   return LBU;
			OP_LHU:   return LHU;
			OP_SB:    return SB;
			OP_SH:    return SH;
			OP_SW:    return SW;
			default:  return II;
		endcase
	endfunction

	always_comb
	begin
		op_d = base_op(s1_insn);
		a_sel_d = SRC_NONE;
		b_sel_d = SRC_NONE;
		dst_sel_d = DST_NONE;
		imm_sel_d = IMM_ZERO;
		br_pred_d = 1'b0;
		is_br_d = 1'b0;
		is_mem_d = 1'b0;
		is_store_d = 1'b0;
		delay_d = 1'b0;
		fold_d = 1'b0;
		case (op_d)
			SLL, SRL, SRA:
			begin
				a_sel_d = SRC_RT;
				b_sel_d = SRC_SHAMT; // shift amount rides in src_b, not a register
				dst_sel_d = DST_RD;
				fold_d = 1'b1;
			end
			SLLV, SRLV, SRAV, ADDU, AND, OR, XOR, NOR, SLT, SLTU:
			begin
				a_sel_d = SRC_RT;
				b_sel_d = SRC_RS;
				dst_sel_d = DST_RD;
				fold_d = 1'b1;
			end
			SUBU:
			begin
				a_sel_d = SRC_RS; // not commutative, keep rs - rt order
				b_sel_d = SRC_RT;
				dst_sel_d = DST_RD;
				fold_d = 1'b1;
			end
			MOV:
			begin
				a_sel_d = SRC_RT;
				dst_sel_d = DST_RD;
				fold_d = 1'b1;
			end
			ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, MOVI, LUI:
			begin
				a_sel_d = (op_d == MOVI || op_d == LUI) ? SRC_NONE : SRC_RS;
				dst_sel_d = DST_RT;
				imm_sel_d = IMM_16;
				fold_d = 1'b1;
			end
			LB, LH, LW, LBU, LHU, SB, SH, SW:
			begin
				is_store_d = (op_d == SB || op_d == SH || op_d == SW);
				a_sel_d = SRC_RS; // base
				b_sel_d = is_store_d ? SRC_RT : SRC_NONE;
				dst_sel_d = is_store_d ? DST_NONE : DST_RT;
				imm_sel_d = IMM_16;
				is_mem_d = 1'b1;
				fold_d = !is_store_d;
			end
			BEQ, BNE, BEQL, BNEL, BLEZ, BGTZ, BLEZL, BGTZL,
			BLTZ, BGEZ, BLTZL, BGEZL, BGEZAL, BAL:
			begin
				a_sel_d = SRC_RS;
				if (op_d == BEQ || op_d == BNE || op_d == BEQL || op_d == BNEL)
					b_sel_d = SRC_RT;
				else if (op_d == BGEZAL)
					b_sel_d = SRC_LINK; // old r31 still needed
				if (op_d == BGEZAL || op_d == BAL)
					dst_sel_d = DST_LINK;
				imm_sel_d = IMM_16;
				br_pred_d = s1_pred;
				is_br_d = 1'b1;
				delay_d = 1'b1;
			end
			J:
			begin
				is_br_d = 1'b1; // target resolved at fetch
				delay_d = 1'b1;
			end
			JAL:
			begin
				dst_sel_d = DST_LINK;
				imm_sel_d = IMM_JUMP;
				br_pred_d = 1'b1;
				is_br_d = 1'b1;
				delay_d = 1'b1;
			end
			JR, JALR:
			begin
				a_sel_d = SRC_RS;
				dst_sel_d = (op_d == JALR) ? DST_RD : DST_NONE;
				imm_sel_d = IMM_PRED;
				is_br_d = 1'b1;
				delay_d = 1'b1;
			end
			default:
				fold_d = 1'b0; // II leaves every selector at none
		endcase
		nullify_d = (op_d inside {BEQL, BNEL, BLEZL, BGTZL, BLTZL, BGEZL});
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			s2_valid <= 1'b0;
		else
			s2_valid <= s1_valid;
	end

	always_ff @(posedge clk)
	begin
		if (s1_valid)
		begin
			s2_insn <= s1_insn;
			s2_pc <= s1_pc;
			s2_pht_idx <= s1_pht_idx;
			s2_pred_target <= s1_pred_target;
			s2_op <= op_d;
			src_a_sel <= a_sel_d;
			src_b_sel <= b_sel_d;
			dst_sel <= dst_sel_d;
			imm_sel <= imm_sel_d;
			s2_br_pred <= br_pred_d;
			s2_is_br <= is_br_d;
			s2_is_mem <= is_mem_d;
			s2_is_store <= is_store_d;
			s2_has_delay_slot <= delay_d;
			s2_has_nullifying_delay_slot <= nullify_d;
			may_fold <= fold_d;
		end
	end

endmodule

// ==== logic/insn_capture.sv ====
`timescale 1ns/10ps

module insn_capture #(
	parameter int PC_W = 32
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   insn_valid,
	input  logic [31:0]            insn,
	input  logic [PC_W-1:0]        pc,
	input  logic                   insn_pred,
	input  logic [7:0]             pht_idx,
	input  logic [PC_W-1:0]        insn_pred_target,
	output logic                   s1_valid,
	output decode_pkg::insn_word_t s1_insn,
	output logic [PC_W-1:0]        s1_pc,
	output logic                   s1_pred,
	output logic [7:0]             s1_pht_idx,
	output logic [PC_W-1:0]        s1_pred_target
);

	// strobe only, no stall path
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			s1_valid <= 1'b0;
		else
			s1_valid <= insn_valid;
	end

	always_ff @(posedge clk)
	begin
		if (insn_valid)
		begin
			s1_insn        <= insn; // raw word, viewed through the union downstream
			s1_pc          <= pc;
			s1_pred        <= insn_pred;
			s1_pht_idx     <= pht_idx;
			s1_pred_target <= insn_pred_target;
		end
	end

endmodule

// ==== logic/decode_pkg.sv ====
package decode_pkg;

	// major opcodes, insn[31:26]
	localparam logic [5:0] OP_SPECIAL = 6'd0;
	localparam logic [5:0] OP_REGIMM  = 6'd1;
	localparam logic [5:0] OP_J       = 6'd2;
	localparam logic [5:0] OP_JAL     = 6'd3;
	localparam logic [5:0] OP_BEQ     = 6'd4;
	localparam logic [5:0] OP_BNE     = 6'd5;
	localparam logic [5:0] OP_BLEZ    = 6'd6;
	localparam logic [5:0] OP_BGTZ    = 6'd7;
	localparam logic [5:0] OP_ADDIU   = 6'd9;
	localparam logic [5:0] OP_SLTI    = 6'd10;
	localparam logic [5:0] OP_SLTIU   = 6'd11;
	localparam logic [5:0] OP_ANDI    = 6'd12;
	localparam logic [5:0] OP_ORI     = 6'd13;
	localparam logic [5:0] OP_XORI    = 6'd14;
	localparam logic [5:0] OP_LUI     = 6'd15;
	localparam logic [5:0] OP_BEQL    = 6'd20;
	localparam logic [5:0] OP_BNEL    = 6'd21;
	localparam logic [5:0] OP_BLEZL   = 6'd22;
	localparam logic [5:0] OP_BGTZL   = 6'd23;
	localparam logic [5:0] OP_LB      = 6'd32;
	localparam logic [5:0] OP_LH      = 6'd33;
	localparam logic [5:0] OP_LW      = 6'd35;
	localparam logic [5:0] OP_LBU     = 6'd36;
	localparam logic [5:0] OP_LHU     = 6'd37;
	localparam logic [5:0] OP_SB      = 6'd40;
	localparam logic [5:0] OP_SH      = 6'd41;
	localparam logic [5:0] OP_SW      = 6'd43;

	// SPECIAL function codes, insn[5:0]
	localparam logic [5:0] FN_SLL  = 6'd0;
	localparam logic [5:0] FN_SRL  = 6'd2;
	localparam logic [5:0] FN_SRA  = 6'd3;
	localparam logic [5:0] FN_SLLV = 6'd4;
	localparam logic [5:0] FN_SRLV = 6'd6;
	localparam logic [5:0] FN_SRAV = 6'd7;
	localparam logic [5:0] FN_JR   = 6'd8;
	localparam logic [5:0] FN_JALR = 6'd9;
	localparam logic [5:0] FN_ADDU = 6'd33;
	localparam logic [5:0] FN_SUBU = 6'd35;
	localparam logic [5:0] FN_AND  = 6'd36;
	localparam logic [5:0] FN_OR   = 6'd37;
	localparam logic [5:0] FN_XOR  = 6'd38;
	localparam logic [5:0] FN_NOR  = 6'd39;
	localparam logic [5:0] FN_SLT  = 6'd42;
	localparam logic [5:0] FN_SLTU = 6'd43;

	// REGIMM selects on the rt field
	localparam logic [4:0] RT_BLTZ   = 5'd0;
	localparam logic [4:0] RT_BGEZ   = 5'd1;
	localparam logic [4:0] RT_BLTZL  = 5'd2;
	localparam logic [4:0] RT_BGEZL  = 5'd3;
	localparam logic [4:0] RT_BGEZAL = 5'd17;

	localparam logic [4:0] REG_LINK = 5'd31;

	typedef enum logic [5:0] {
		NOP, II, MOV, MOVI,
		SLL, SRL, SRA, SLLV, SRLV, SRAV,
		ADDU, SUBU, AND, OR, XOR, NOR, SLT, SLTU,
		ADDIU, SLTI, SLTIU, ANDI, ORI, XORI, LUI,
		LB, LH, LW, LBU, LHU, SB, SH, SW,
		BEQ, BNE, BLEZ, BGTZ, BEQL, BNEL, BLEZL, BGTZL,
		BLTZ, BGEZ, BLTZL, BGEZL, BGEZAL, BAL,
		J, JAL, JR, JALR
	} uop_op_t;

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} insn_r_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} insn_i_t;

	// one fetched word, seen as R or I format
	typedef union packed {
		insn_r_t r;
		insn_i_t i;
	} insn_word_t;

	typedef enum logic [2:0] {SRC_NONE, SRC_RS, SRC_RT, SRC_SHAMT, SRC_LINK} src_sel_t;
	typedef enum logic [1:0] {DST_NONE, DST_RD, DST_RT, DST_LINK} dst_sel_t;
	typedef enum logic [1:0] {IMM_ZERO, IMM_16, IMM_JUMP, IMM_PRED} imm_sel_t;

endpackage
